/* verification/ooo_stimulus.txt */
# I op rd rs1 rs2 imm burst exp_rd exp_value   (hex; op 0 add 1 sub 2 and 3 or 4 xor 5 slt 6 addi 7 mul)
# R reg value   final register contents; burst 1 means no idle gap before the instruction
I 6 1 0 0 00000005 0 1 00000005
I 6 2 0 0 fffffffd 0 2 fffffffd
I 6 3 0 0 0000f0f0 0 3 0000f0f0
I 6 4 0 0 00ff00ff 0 4 00ff00ff
I 0 5 1 2 00000000 0 5 00000002
I 1 6 1 2 00000000 0 6 00000008
I 2 7 3 4 00000000 0 7 000000f0
I 3 5 3 4 00000000 0 5 00fff0ff
I 4 6 3 4 00000000 0 6 00fff00f
I 5 7 2 1 00000000 0 7 00000001
I 6 1 1 0 00000001 0 1 00000006
I 0 1 1 1 00000000 1 1 0000000c
I 1 1 1 2 00000000 1 1 0000000f
I 3 2 1 7 00000000 1 2 0000000f
I 7 3 1 2 00000000 0 3 000000e1
I 6 4 0 0 00000007 1 4 00000007
I 7 5 3 3 00000000 1 5 0000c5c1
I 0 6 4 4 00000000 1 6 0000000e
I 7 7 4 6 00000000 1 7 00000062
I 6 4 0 0 00010001 0 4 00010001
I 7 4 4 4 00000000 1 4 00020001
I 6 0 1 0 00000100 0 0 0000010f
I 0 2 0 3 00000000 1 2 000000e1
I 7 1 1 1 00000000 0 1 000000e1
I 7 1 1 1 00000000 1 1 0000c5c1
I 7 1 1 1 00000000 1 1 98c29b81
I 6 2 1 0 00000001 1 2 98c29b82
I 1 3 2 1 00000000 1 3 00000001
I 2 4 1 2 00000000 1 4 98c29b80
I 3 5 3 4 00000000 1 5 98c29b81
I 5 6 1 0 00000000 1 6 00000001
I 4 7 5 1 00000000 1 7 00000000
I 7 2 3 6 00000000 1 2 00000001
I 0 0 2 2 00000000 1 0 00000002
I 6 7 7 0 7fffffff 1 7 7fffffff
I 5 6 7 1 00000000 1 6 00000000
R 0 00000000
R 1 98c29b81
R 2 00000001
R 3 00000001
R 4 98c29b80
R 5 98c29b81
R 6 00000000
R 7 7fffffff

/* src.f */
rtl/ooo_pkg.sv
rtl/dispatcher.sv
rtl/reservation_station.sv
rtl/execute_units.sv
rtl/reorder_buffer.sv
rtl/register_file.sv
rtl/ooo_core.sv
verification/ooo_core_properties.sv
verification/ooo_core_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run from the project root, decide on the simulation log
verilator --binary --assert -Wno-fatal --top-module ooo_core_tb -f src.f -o ooo_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/ooo_sim > sim.log 2>&1
grep -q "TEST FAILED" sim.log && { cat sim.log; exit 1; }
grep -q "TEST PASSED" sim.log || { cat sim.log; echo "simulation ended without a result"; exit 1; }
cat sim.log
exit 0

/* verification/ooo_core_tb.sv */
module ooo_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic                clock;
    logic                reset;
    logic                instr_valid;
    ooo_pkg::inst_t      instr;
    logic                stall;
    ooo_pkg::commit_t    commit;
    ooo_pkg::reg_file_t  registers;

    ooo_pkg::inst_t      prog_q[$];      // program order
    logic                burst_q[$];     // 1 = no idle gap before this one
    ooo_pkg::commit_t    expect_q[$];    // expected retire stream
    ooo_pkg::data_t      final_regs[ooo_pkg::reg_num];
    int                  num_instr;
    int                  commits_seen;
    logic                stall_seen;
    int                  wait_limit;     // cycles per wait loop

    ooo_core u_dut (
        .clock       (clock),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .commit      (commit),
        .registers   (registers)
    );

    always #2 clock = ~clock;    // 4 ns period

    //////////////////////////////
    // failure and compare
    //////////////////////////////
    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_commit(input ooo_pkg::commit_t got, input ooo_pkg::commit_t exp);
        if (got.rd !== exp.rd || got.value !== exp.value) begin
            $display("Mismatch at %0t: commit %0d expected rd %0d value %h, got rd %0d value %h",
                     $time, commits_seen, exp.rd, exp.value, got.rd, got.value);
            stop_with_failure("commit record differs from the expected one");
        end
    endtask

    task automatic check_register(input int idx, input ooo_pkg::data_t got,
                                  input ooo_pkg::data_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: register x%0d expected %h got %h", $time, idx, exp, got);
            stop_with_failure("final register contents differ");
        end
    endtask

    //////////////////////////////
    // stimulus file
    //////////////////////////////
    task automatic load_stimulus();
        int             fd;
        int             n;
        string          line;
        logic [31:0]    op_f, rd_f, rs1_f, rs2_f, imm_f, burst_f, erd_f, eval_f;
        ooo_pkg::inst_t   inst;
        ooo_pkg::commit_t exp;
        fd = $fopen("verification/ooo_stimulus.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open verification/ooo_stimulus.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) == "I") begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h %h %h",
                            op_f, rd_f, rs1_f, rs2_f, imm_f, burst_f, erd_f, eval_f);
                if (n != 8) begin
                    stop_with_failure("malformed instruction line in the stimulus file");
                end
                inst.op    = ooo_pkg::op_t'(op_f[2:0]);
                inst.rd    = ooo_pkg::reg_idx_t'(rd_f);
                inst.rs1   = ooo_pkg::reg_idx_t'(rs1_f);
                inst.rs2   = ooo_pkg::reg_idx_t'(rs2_f);
                inst.imm   = imm_f;
                exp.valid  = 1'b1;
                exp.rd     = ooo_pkg::reg_idx_t'(erd_f);
                exp.value  = eval_f;
                prog_q.push_back(inst);
                burst_q.push_back(burst_f[0]);
                expect_q.push_back(exp);
            end else if (line.len() > 1 && line.getc(0) == "R") begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h", rd_f, eval_f);
                if (n != 2) begin
                    stop_with_failure("malformed register line in the stimulus file");
                end
                final_regs[rd_f[2:0]] = eval_f;
            end
        end
        $fclose(fd);
        num_instr = prog_q.size();
    endtask

    //////////////////////////////
    // driver
    //////////////////////////////
    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            instr_valid <= 1'b0;
        end
    endtask

    // present one instruction and hold it until a stall-free edge takes it
    task automatic send_instruction(input ooo_pkg::inst_t inst);
        int waited;
        @(posedge clock);
        instr_valid <= 1'b1;
        instr       <= inst;
        waited = 0;
        @(negedge clock);
        while (stall) begin
            waited++;
            if (waited > wait_limit) begin
                stop_with_failure("stall stayed high too long, dispatch never resumed");
            end
            @(negedge clock);
        end
    endtask    // accepted at the next rising edge

    task automatic wait_for_commits();
        int waited;
        waited = 0;
        while (commits_seen < num_instr) begin
            waited++;
            if (waited > wait_limit * 4) begin
                stop_with_failure("timed out waiting for all instructions to commit");
            end
            @(negedge clock);
        end
    endtask

    //////////////////////////////
    // commit monitor
    //////////////////////////////
    always @(negedge clock) begin
        if (!reset && stall) begin
            stall_seen = 1'b1;
        end
        if (!reset && commit.valid) begin
            if (expect_q.size() == 0) begin
                stop_with_failure("commit pulse with no instruction left to retire");
            end else begin
                check_commit(commit, expect_q.pop_front());
                commits_seen++;
            end
        end
    end

    initial begin
        int gap;
        void'($urandom(32'ha190));
        clock        = 1'b0;
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        commits_seen = 0;
        stall_seen   = 1'b0;
        wait_limit   = 200;
        load_stimulus();
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        for (int i = 0; i < num_instr; i++) begin
            if (!burst_q[i]) begin
                gap = $urandom % 4;
                drive_idle(gap);
            end
            send_instruction(prog_q[i]);
        end
        drive_idle(1);
        wait_for_commits();
        repeat (8) @(negedge clock);    // let the last write land and catch stray commits
        for (int r = 0; r < ooo_pkg::reg_num; r++) begin
            check_register(r, registers[r], final_regs[r]);
        end
        if (!stall_seen) begin
            stop_with_failure("stall never rose during the burst");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

/* verification/ooo_core_properties.sv */
module ooo_core_properties (
    input logic                clock,
    input logic                reset,
    input logic                stall,
    input ooo_pkg::commit_t    commit,
    input ooo_pkg::issue_t     issue,
    input ooo_pkg::cdb_t       cdb,
    input ooo_pkg::rob_state_t cdb_state,    // rob state of the slot on the bus
    input logic                rob_alloc,
    input ooo_pkg::rob_tag_t   rob_tail,     // next tag to hand out
    input ooo_pkg::rob_tag_t   rob_head
);

    timeunit 1ns;
    timeprecision 100ps;

    // allocated slots whose commit pulse has not shown up yet
    logic [$clog2(ooo_pkg::rob_size):0] in_flight;

    always_ff @(posedge clock) begin
        if (reset) begin
            in_flight <= '0;
        end else begin
            case ({rob_alloc, commit.valid})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

    // first cycle out of reset is quiet
    a_quiet_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> !commit.valid && !stall && !issue.valid && !cdb.valid)
        else $error("commit, stall, issue or bus active right after reset");

    // broadcast only for slots still waiting
    a_cdb_tag_waiting: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> cdb_state == ooo_pkg::rob_waiting)
        else $error("bus broadcast for a rob slot that is not waiting");

    // the retired slot is the oldest allocated one, so tags retire back to back
    a_commit_in_order: assert property (@(posedge clock) disable iff (reset)
        commit.valid |-> in_flight != 0
            && $past(rob_head) == ooo_pkg::rob_tag_t'(rob_tail - ooo_pkg::rob_tag_t'(in_flight)))
        else $error("commit with nothing allocated or out of tag order");

endmodule

bind ooo_core ooo_core_properties u_properties (
    .clock     (clock),
    .reset     (reset),
    .stall     (stall),
    .commit    (commit),
    .issue     (issue),
    .cdb       (cdb),
    .cdb_state (u_rob.state[cdb.tag]),
    .rob_alloc (rob_alloc),
    .rob_tail  (rob_tag),
    .rob_head  (u_rob.head)
);

/* rtl/ooo_core.sv */
module ooo_core (
    input  logic               clock,
    input  logic               reset,
    input  logic               instr_valid,
    input  ooo_pkg::inst_t     instr,
    output logic               stall,
    output ooo_pkg::commit_t   commit,
    output ooo_pkg::reg_file_t registers
);

    // dispatch <-> rob
    ooo_pkg::rob_tag_t        rob_tag;
    logic                     rob_full;
    logic                     rob_alloc;
    ooo_pkg::reg_idx_t        rob_rd;
    logic [1:0]               src_pending;
    ooo_pkg::rob_tag_t [1:0]  src_tag;
    logic [1:0]               src_done;
    ooo_pkg::data_t [1:0]     src_done_value;

    // dispatch -> rs -> execute
    logic                     rs_full;
    logic                     rs_load;
    ooo_pkg::rs_entry_t       rs_entry;
    ooo_pkg::issue_t          issue;
    logic                     alu_free;
    ooo_pkg::cdb_t            cdb;

    //////////////////////////////
    // dispatch
    //////////////////////////////
    dispatcher u_dispatcher (
        .clock          (clock),
        .reset          (reset),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .registers      (registers),
        .rob_tag        (rob_tag),
        .rob_full       (rob_full),
        .src_pending    (src_pending),
        .src_tag        (src_tag),
        .src_done_value (src_done_value),
        .src_done       (src_done),
        .rs_full        (rs_full),
        .cdb            (cdb),
        .stall          (stall),
        .rs_load        (rs_load),
        .rs_entry       (rs_entry),
        .rob_alloc      (rob_alloc),
        .rob_rd         (rob_rd)
    );

    //////////////////////////////
    // issue and execute
    //////////////////////////////
    reservation_station u_rs (
        .clock    (clock),
        .reset    (reset),
        .load     (rs_load),
        .entry_in (rs_entry),
        .cdb      (cdb),
        .alu_free (alu_free),
        .full     (rs_full),
        .issue    (issue)
    );

    execute_units u_execute (
        .clock    (clock),
        .reset    (reset),
        .issue    (issue),
        .alu_free (alu_free),
        .cdb      (cdb)
    );

    //////////////////////////////
    // complete and retire
    //////////////////////////////
    reorder_buffer u_rob (
        .clock          (clock),
        .reset          (reset),
        .alloc          (rob_alloc),
        .alloc_rd       (rob_rd),
        .cdb            (cdb),
        .lookup_reg     ({instr.rs2, instr.rs1}),    // same order as dispatcher
        .tag            (rob_tag),
        .full           (rob_full),
        .src_pending    (src_pending),
        .src_tag        (src_tag),
        .src_done       (src_done),
        .src_done_value (src_done_value),
        .commit         (commit)
    );

    register_file u_regfile (
        .clock     (clock),
        .reset     (reset),
        .commit    (commit),
        .registers (registers)
    );

endmodule

/* rtl/register_file.sv */
module register_file (
    input  logic               clock,
    input  logic               reset,
    input  ooo_pkg::commit_t   commit,
    output ooo_pkg::reg_file_t registers
);

    ooo_pkg::reg_file_t regs;

    // architectural state, written in program order
    always_ff @(posedge clock) begin
        if (reset) begin
            regs <= '0;
        end else if (commit.valid && commit.rd != '0) begin
            regs[commit.rd] <= commit.value;
        end
    end

    always_comb begin
        registers    = regs;
        registers[0] = '0;      // x0 hardwired
    end

endmodule

/* rtl/reorder_buffer.sv */
module reorder_buffer (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    alloc,
    input  ooo_pkg::reg_idx_t       alloc_rd,
    input  ooo_pkg::cdb_t           cdb,
    input  ooo_pkg::reg_idx_t [1:0] lookup_reg,
    output ooo_pkg::rob_tag_t       tag,
    output logic                    full,
    output logic [1:0]              src_pending,
    output ooo_pkg::rob_tag_t [1:0] src_tag,
    output logic [1:0]              src_done,
    output ooo_pkg::data_t [1:0]    src_done_value,
    output ooo_pkg::commit_t        commit
);

    ooo_pkg::rob_state_t                  state [ooo_pkg::rob_size];
    ooo_pkg::reg_idx_t                    dest  [ooo_pkg::rob_size];
    ooo_pkg::data_t                       value [ooo_pkg::rob_size];
    ooo_pkg::rob_tag_t                    head;
    ooo_pkg::rob_tag_t                    tail;
    logic [$clog2(ooo_pkg::rob_size):0]   count;
    logic                                 retire;

    // rename table: youngest in-flight producer per register
    logic [ooo_pkg::reg_num-1:0]          map_valid;
    ooo_pkg::rob_tag_t                    map_tag [ooo_pkg::reg_num];

    assign tag    = tail;
    assign full   = count == ooo_pkg::rob_size;
    assign retire = state[head] == ooo_pkg::rob_done;

    //////////////////////////////
    // source lookup
    //////////////////////////////
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src_pending[s]    = map_valid[lookup_reg[s]];
            src_tag[s]        = map_tag[lookup_reg[s]];
            src_done[s]       = state[src_tag[s]] == ooo_pkg::rob_done;
            src_done_value[s] = value[src_tag[s]];
            // committed last edge, register file one cycle behind
            if (!map_valid[lookup_reg[s]] && commit.valid && commit.rd == lookup_reg[s]
                && lookup_reg[s] != '0) begin
                src_pending[s]    = 1'b1;
                src_done[s]       = 1'b1;
                src_done_value[s] = commit.value;
            end
        end
    end

    //////////////////////////////
    // allocate, complete, commit
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            map_valid <= '0;
            commit    <= '0;
            for (int i = 0; i < ooo_pkg::rob_size; i++) begin
                state[i] <= ooo_pkg::rob_empty;
            end
        end else begin
            commit.valid <= retire;         // one pulse per retired entry
            commit.rd    <= dest[head];
            commit.value <= value[head];
            if (retire) begin
                state[head] <= ooo_pkg::rob_empty;
                head        <= head + 1'b1;
                // only clear if no younger writer took the register
                if (map_valid[dest[head]] && map_tag[dest[head]] == head) begin
                    map_valid[dest[head]] <= 1'b0;
                end
            end
            if (cdb.valid) begin
                state[cdb.tag] <= ooo_pkg::rob_done;
                value[cdb.tag] <= cdb.value;
            end
            if (alloc) begin
                state[tail] <= ooo_pkg::rob_waiting;
                dest[tail]  <= alloc_rd;
                tail        <= tail + 1'b1;
                if (alloc_rd != '0) begin   // x0 never renamed
                    map_valid[alloc_rd] <= 1'b1;
                    map_tag[alloc_rd]   <= tail;
                end
            end
            case ({alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* rtl/execute_units.sv */
module execute_units (
    input  logic            clock,
    input  logic            reset,
    input  ooo_pkg::issue_t issue,
    output logic            alu_free,
    output ooo_pkg::cdb_t   cdb
);

    ooo_pkg::cdb_t                               alu_q;      // alu output register
    ooo_pkg::cdb_t                               alu_hold;   // result that lost the bus
    ooo_pkg::cdb_t [ooo_pkg::mul_stages-1:0]     mul_pipe;
    ooo_pkg::cdb_t                               mul_out;
    ooo_pkg::data_t                              alu_value;
    logic                                        alu_issue;
    logic                                        mul_issue;
    logic                                        alu_sent;
    logic                                        hold_sent;
    logic                                        alu_park;

    assign alu_issue = issue.valid && issue.op != ooo_pkg::op_mul;
    assign mul_issue = issue.valid && issue.op == ooo_pkg::op_mul;

    //////////////////////////////
    // alu
    //////////////////////////////
    always_comb begin
        case (issue.op)
            ooo_pkg::op_add,
            ooo_pkg::op_addi: alu_value = issue.a + issue.b;   // b is imm for addi
            ooo_pkg::op_sub:  alu_value = issue.a - issue.b;
            ooo_pkg::op_and:  alu_value = issue.a & issue.b;
            ooo_pkg::op_or:   alu_value = issue.a | issue.b;
            ooo_pkg::op_xor:  alu_value = issue.a ^ issue.b;
            ooo_pkg::op_slt:  alu_value = ooo_pkg::data_t'($signed(issue.a) < $signed(issue.b));
            default:          alu_value = '0;                  // mul handled below
        endcase
    end

    //////////////////////////////
    // bus arbitration
    //////////////////////////////
    assign mul_out   = mul_pipe[ooo_pkg::mul_stages-1];
    assign hold_sent = alu_hold.valid && !mul_out.valid;
    assign alu_sent  = alu_q.valid && !mul_out.valid && !alu_hold.valid;
    // move into hold when hold is empty or draining this cycle
    assign alu_park  = alu_q.valid && !alu_sent && (!alu_hold.valid || hold_sent);
    assign alu_free  = !alu_hold.valid;

    // mul first, then the held result, then the fresh one
    always_comb begin
        if (mul_out.valid) begin
            cdb = mul_out;
        end else if (alu_hold.valid) begin
            cdb = alu_hold;
        end else begin
            cdb = alu_q;            // invalid when idle
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            alu_q    <= '0;
            alu_hold <= '0;
        end else begin
            if (alu_issue) begin
                alu_q.valid <= 1'b1;
                alu_q.tag   <= issue.tag;
                alu_q.value <= alu_value;
            end else if (alu_sent || alu_park) begin
                alu_q.valid <= 1'b0;
            end
            if (alu_park) begin
                alu_hold <= alu_q;
            end else if (hold_sent) begin
                alu_hold.valid <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // multiplier
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            mul_pipe <= '0;
        end else begin
            mul_pipe[0].valid <= mul_issue;
            mul_pipe[0].tag   <= issue.tag;
            mul_pipe[0].value <= issue.a * issue.b;      // low 32 bits of product
            for (int i = 1; i < ooo_pkg::mul_stages; i++) begin
                mul_pipe[i] <= mul_pipe[i-1];
            end
        end
    end

endmodule

/* rtl/reservation_station.sv */
module reservation_station (
    input  logic               clock,
    input  logic               reset,
    input  logic               load,
    input  ooo_pkg::rs_entry_t entry_in,
    input  ooo_pkg::cdb_t      cdb,
    input  logic               alu_free,
    output logic               full,
    output ooo_pkg::issue_t    issue
);

    // slot 0 holds the oldest and the rest stay compacted
    ooo_pkg::rs_entry_t [ooo_pkg::rs_size-1:0] entries;
    ooo_pkg::rs_entry_t [ooo_pkg::rs_size-1:0] entries_next;
    logic                                      found;
    int                                        sel;
    logic [$clog2(ooo_pkg::rs_size):0]         count;

    // capture a bus result into a waiting source
    function automatic ooo_pkg::rs_entry_t wake(input ooo_pkg::rs_entry_t e,
                                                 input ooo_pkg::cdb_t c);
        wake = e;
        if (c.valid && !e.src1.ready && e.src1.tag == c.tag) begin
            wake.src1.ready = 1'b1;
            wake.src1.value = c.value;
        end
        if (c.valid && !e.src2.ready && e.src2.tag == c.tag) begin
            wake.src2.ready = 1'b1;
            wake.src2.value = c.value;
        end
    endfunction

    // pick the oldest ready entry and hold back alu ops while the alu is backed up
    always_comb begin
        found = 1'b0;
        sel   = 0;
        count = '0;
        for (int i = 0; i < ooo_pkg::rs_size; i++) begin
            if (entries[i].valid) begin
                count = count + 1'b1;
            end
            if (!found && entries[i].valid && entries[i].src1.ready && entries[i].src2.ready
                && (entries[i].op == ooo_pkg::op_mul || alu_free)) begin
                found = 1'b1;
                sel   = i;
            end
        end
    end

    // the entry sitting in the dispatch register counts as taken
    assign full = (count == ooo_pkg::rs_size) || (count == ooo_pkg::rs_size - 1 && load);

    always_comb begin
        issue.valid = found;
        issue.op    = entries[sel].op;
        issue.tag   = entries[sel].tag;
        issue.a     = entries[sel].src1.value;
        issue.b     = entries[sel].src2.value;
    end

    // drop the issued slot and shift younger ones down before the new one goes on the end
    always_comb begin
        int k;
        k            = 0;
        entries_next = '0;
        for (int i = 0; i < ooo_pkg::rs_size; i++) begin
            if (entries[i].valid && !(found && i == sel)) begin
                entries_next[k] = wake(entries[i], cdb);
                k               = k + 1;
            end
        end
        if (load && k < ooo_pkg::rs_size) begin
            entries_next[k] = wake(entry_in, cdb);   // same-cycle broadcast
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entries <= '0;
        end else begin
            entries <= entries_next;
        end
    end

endmodule

/* rtl/dispatcher.sv */
module dispatcher (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    instr_valid,
    input  ooo_pkg::inst_t          instr,
    input  ooo_pkg::reg_file_t      registers,
    input  ooo_pkg::rob_tag_t       rob_tag,         // slot handed out this cycle
    input  logic                    rob_full,
    input  logic [1:0]              src_pending,     // index 0 is rs1
    input  ooo_pkg::rob_tag_t [1:0] src_tag,
    input  ooo_pkg::data_t [1:0]    src_done_value,
    input  logic [1:0]              src_done,
    input  logic                    rs_full,
    input  ooo_pkg::cdb_t           cdb,
    output logic                    stall,
    output logic                    rs_load,
    output ooo_pkg::rs_entry_t      rs_entry,
    output logic                    rob_alloc,
    output ooo_pkg::reg_idx_t       rob_rd
);

    logic                     accept;
    ooo_pkg::reg_idx_t [1:0]  src_reg;
    ooo_pkg::operand_t [1:0]  src;
    ooo_pkg::rs_entry_t       next_entry;

    assign stall     = rs_full | rob_full;     // no room in rs or rob
    assign accept    = instr_valid & ~stall;
    assign rob_alloc = accept;                 // rob takes the slot at this edge
    assign rob_rd    = instr.rd;
    assign src_reg   = {instr.rs2, instr.rs1};

    // operand source priority: regfile, done rob entry, live bus, else wait on tag
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src[s].tag = src_tag[s];
            if (!src_pending[s]) begin
                src[s].ready = 1'b1;
                src[s].value = registers[src_reg[s]];
            end else if (src_done[s]) begin
                src[s].ready = 1'b1;            // finished, not yet committed
                src[s].value = src_done_value[s];
            end else if (cdb.valid && cdb.tag == src_tag[s]) begin
                src[s].ready = 1'b1;            // producer broadcasting right now
                src[s].value = cdb.value;
            end else begin
                src[s].ready = 1'b0;
                src[s].value = '0;
            end
        end
        // immediate replaces rs2
        if (instr.op == ooo_pkg::op_addi) begin
            src[1].ready = 1'b1;
            src[1].value = instr.imm;
        end
    end

    always_comb begin
        next_entry.valid = 1'b1;
        next_entry.op    = instr.op;
        next_entry.tag   = rob_tag;
        next_entry.src1  = src[0];
        next_entry.src2  = src[1];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rs_load <= 1'b0;
        end else begin
            rs_load <= accept;
        end
    end

    // entry payload, only meaningful with rs_load
    always_ff @(posedge clock) begin
        if (accept) begin
            rs_entry <= next_entry;
        end
    end

endmodule

/* rtl/ooo_pkg.sv */
package ooo_pkg;

    //////////////////////////////
    // sizes
    //////////////////////////////
    localparam int xlen       = 32;
    localparam int reg_num    = 8;
    localparam int rob_size   = 8;
    localparam int rs_size    = 4;
    localparam int mul_stages = 3;     // multiplier latency in cycles

    typedef logic [xlen-1:0]              data_t;
    typedef logic [$clog2(reg_num)-1:0]   reg_idx_t;
    typedef logic [$clog2(rob_size)-1:0]  rob_tag_t;   // rob slot doubles as rename tag
    typedef data_t [reg_num-1:0]          reg_file_t;

    typedef enum logic [2:0] {
        op_add, op_sub, op_and, op_or, op_xor, op_slt, op_addi, op_mul
    } op_t;

    // decoded instruction from the front end
    typedef struct packed {
        op_t      op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        data_t    imm;      // addi only
    } inst_t;

    // one source operand, value valid once ready
    typedef struct packed {
        logic     ready;
        rob_tag_t tag;
        data_t    value;
    } operand_t;

    typedef struct packed {
        logic     valid;
        op_t      op;
        rob_tag_t tag;      // destination rob slot
        operand_t src1;
        operand_t src2;
    } rs_entry_t;

    typedef struct packed {
        logic     valid;
        op_t      op;
        rob_tag_t tag;
        data_t    a;
        data_t    b;
    } issue_t;

    // common data bus, one result per cycle
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        data_t    value;
    } cdb_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        data_t    value;
    } commit_t;

    typedef enum logic [1:0] {
        rob_empty, rob_waiting, rob_done
    } rob_state_t;

endpackage
